// File: common/tcdm_settings.svh
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

// data path width and its split into ecc chunks
`define TCDM_DW       64
`define TCDM_CHUNK    32
`define TCDM_N_CHUNK  2

// byte address, one enable per byte
`define TCDM_AW       10
`define TCDM_BW       8

// add + wen + be
`define TCDM_META_W   19

// hsiao check bits per protected field
`define TCDM_EW_DW    7
`define TCDM_EW_META  7

// full ecc word on the port, data chunks above metadata
`define TCDM_EW       21

// bank size in data words
`define TCDM_DEPTH    128

`endif

// File: common/hci_ecc_pkg.sv
`include "tcdm_settings.svh"

package hci_ecc_pkg;

  // request ecc split, chunk check bits on top, metadata check bits at the bottom
  typedef struct packed {
    logic [`TCDM_N_CHUNK-1:0][`TCDM_EW_DW-1:0] data_ecc;
    logic [`TCDM_EW_META-1:0]                  meta_ecc;
  } ecc_fields_t;

  // same request ecc word, either as it arrives or by field
  typedef union packed {
    logic [`TCDM_EW-1:0] raw;
    ecc_fields_t         fields;
  } ecc_word_u;

  // one flag pair per data chunk plus one for the metadata
  typedef struct packed {
    logic [`TCDM_N_CHUNK-1:0] data_single;
    logic [`TCDM_N_CHUNK-1:0] data_multi;
    logic                     meta_single;
    logic                     meta_multi;
  } ecc_err_t;

  // h-matrix column of data bit j
  // odd weight >= 3 patterns, by weight then by value
  function automatic int unsigned hsiao_col(int unsigned prot_w, int unsigned j);
    int unsigned idx;
    int unsigned ones;
    int unsigned col;
    idx = 0;
    col = 0;
    for (int unsigned w = 3; w <= prot_w; w += 2) begin
      for (int unsigned v = 0; v < (32'd1 << prot_w); v++) begin
        ones = 0;
        for (int unsigned b = 0; b < prot_w; b++) begin
          ones += (v >> b) & 32'd1;
        end
        if (ones == w) begin
          // first match wins, later hits have higher idx
          if (idx == j) col = v;
          idx++;
        end
      end
    end
    return col;
  endfunction

endpackage

// File: common/tcdm_pkg.sv
`include "tcdm_settings.svh"

package tcdm_pkg;

  // request metadata as covered by the metadata ecc
  // add on top, be at the bottom
  typedef struct packed {
    logic [`TCDM_AW-1:0] add;
    // high = write
    logic                wen;
    logic [`TCDM_BW-1:0] be;
  } tcdm_meta_t;

  // one memory / bus data word
  typedef logic [`TCDM_DW-1:0] tcdm_word_t;

  // word index inside the bank
  typedef logic [$clog2(`TCDM_DEPTH)-1:0] tcdm_waddr_t;

  // byte offset bits dropped from add to get the word index
  localparam int unsigned TCDM_BOFFS_W = $clog2(`TCDM_BW);

endpackage

// File: common/hci_core_intf.sv
`include "tcdm_settings.svh"

// tcdm request / response bundle, no handshake beyond req/gnt and r_valid
interface hci_core_intf;

  // request phase
  logic                req;
  logic                gnt;
  logic [`TCDM_AW-1:0] add;
  // wen high = write, low = read
  logic                wen;
  logic [`TCDM_BW-1:0] be;
  logic [`TCDM_DW-1:0] data;
  logic [`TCDM_EW-1:0] ecc;

  // response phase
  logic                r_valid;
  logic [`TCDM_DW-1:0] r_data;
  logic [`TCDM_EW-1:0] r_ecc;

  // memory side
  modport target (
    input  req, add, wen, be, data, ecc,
    output gnt, r_valid, r_data, r_ecc
  );

  // requester side
  modport initiator (
    output req, add, wen, be, data, ecc,
    input  gnt, r_valid, r_data, r_ecc
  );

endinterface

// File: ecc/hsiao_ecc_enc.sv
module hsiao_ecc_enc
  import hci_ecc_pkg::*;
#(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned PROT_W = 7
) (
  input  logic [DATA_W-1:0] data_i,
  output logic [PROT_W-1:0] ecc_o
);

  // one h-matrix column per data bit, fixed at elaboration
  logic [DATA_W-1:0][PROT_W-1:0] h_cols;

  for (genvar j = 0; j < DATA_W; j++) begin : gen_col
    localparam logic [PROT_W-1:0] COL = PROT_W'(hsiao_col(PROT_W, j));
    assign h_cols[j] = COL;
  end

  // check bit i = xor of all data bits whose column has bit i set
  always_comb begin
    ecc_o = '0;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      ecc_o ^= h_cols[j] & {PROT_W{data_i[j]}};
    end
  end

  // enough non-unit odd-weight patterns for every data bit
  initial begin
    assert (DATA_W <= (2 ** (PROT_W - 1)) - PROT_W)
      else $error("hsiao_ecc_enc: %0d check bits too few for %0d data bits",
                  PROT_W, DATA_W);
  end

endmodule

// File: ecc/hsiao_ecc_dec.sv
module hsiao_ecc_dec
  import hci_ecc_pkg::*;
#(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned PROT_W = 7
) (
  input  logic [DATA_W-1:0] data_i,
  input  logic [PROT_W-1:0] ecc_i,
  output logic [DATA_W-1:0] data_o,
  output logic              single_err_o,
  output logic              multi_err_o
);

  logic [DATA_W-1:0][PROT_W-1:0] h_cols;
  logic [PROT_W-1:0]             syndrome;
  // syndrome hits a data column
  logic                          data_hit;
  // syndrome hits a check-bit column
  logic                          unit_hit;

  for (genvar j = 0; j < DATA_W; j++) begin : gen_col
    localparam logic [PROT_W-1:0] COL = PROT_W'(hsiao_col(PROT_W, j));
    assign h_cols[j] = COL;
  end

  // recomputed check bits against the received ones
  always_comb begin
    syndrome = ecc_i;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      syndrome ^= h_cols[j] & {PROT_W{data_i[j]}};
    end
  end

  // flip the one data bit whose column equals the syndrome
  always_comb begin
    data_o   = data_i;
    data_hit = 1'b0;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      if (syndrome == h_cols[j]) begin
        data_o[j] = ~data_i[j];
        data_hit  = 1'b1;
      end
    end
  end

  // single one in the syndrome, check bit itself was hit
  assign unit_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

  assign single_err_o = data_hit | unit_hit;
  // nonzero but no column matches, leave data alone
  assign multi_err_o  = (syndrome != '0) & ~data_hit & ~unit_hit;

  // single and multi exclude each other
  always_comb begin
    assert (!(single_err_o && multi_err_o))
      else $error("hsiao_ecc_dec: single and multi error together");
  end

endmodule

// File: ecc/hci_ecc_dec.sv
`include "tcdm_settings.svh"

module hci_ecc_dec
  import hci_ecc_pkg::*;
  import tcdm_pkg::*;
(
  hci_core_intf.target    tgt,
  hci_core_intf.initiator init,
  output ecc_err_t        err_o
);

  // unused upper bits of r_ecc
  localparam int unsigned R_PAD = `TCDM_EW - `TCDM_N_CHUNK * `TCDM_EW_DW;

  ecc_word_u                                    req_ecc;
  tcdm_meta_t                                   meta_in;
  tcdm_meta_t                                   meta_dec;
  logic [`TCDM_N_CHUNK-1:0][`TCDM_CHUNK-1:0]    data_dec;
  logic [`TCDM_N_CHUNK-1:0]                     data_single;
  logic [`TCDM_N_CHUNK-1:0]                     data_multi;
  logic                                         meta_single;
  logic                                         meta_multi;
  logic [`TCDM_N_CHUNK-1:0][`TCDM_EW_DW-1:0]    r_data_ecc;

  // port ecc comes in flat, decoders take it by field
  assign req_ecc.raw = tgt.ecc;

  // data chunks, each with its own check bits
  for (genvar ii = 0; ii < `TCDM_N_CHUNK; ii++) begin : gen_data_dec
    hsiao_ecc_dec #(
      .DATA_W ( `TCDM_CHUNK ),
      .PROT_W ( `TCDM_EW_DW )
    ) i_data_dec (
      .data_i       ( tgt.data[ii*`TCDM_CHUNK +: `TCDM_CHUNK] ),
      .ecc_i        ( req_ecc.fields.data_ecc[ii]             ),
      .data_o       ( data_dec[ii]                            ),
      .single_err_o ( data_single[ii]                         ),
      .multi_err_o  ( data_multi[ii]                          )
    );
  end

  // metadata decoded in parallel with the data
  assign meta_in = '{add: tgt.add, wen: tgt.wen, be: tgt.be};

  hsiao_ecc_dec #(
    .DATA_W ( `TCDM_META_W  ),
    .PROT_W ( `TCDM_EW_META )
  ) i_meta_dec (
    .data_i       ( meta_in                 ),
    .ecc_i        ( req_ecc.fields.meta_ecc ),
    .data_o       ( meta_dec                ),
    .single_err_o ( meta_single             ),
    .multi_err_o  ( meta_multi              )
  );

  // corrected request towards the bank
  // uncorrectable metadata means unknown address, so the request is dropped
  assign init.req  = tgt.req & ~meta_multi;
  assign init.add  = meta_dec.add;
  assign init.wen  = meta_dec.wen;
  assign init.be   = meta_dec.be;
  assign init.data = data_dec;
  // bank keeps no check bits
  assign init.ecc  = '0;

  // response check bits rebuilt from the bank data
  for (genvar ii = 0; ii < `TCDM_N_CHUNK; ii++) begin : gen_r_data_enc
    hsiao_ecc_enc #(
      .DATA_W ( `TCDM_CHUNK ),
      .PROT_W ( `TCDM_EW_DW )
    ) i_r_data_enc (
      .data_i ( init.r_data[ii*`TCDM_CHUNK +: `TCDM_CHUNK] ),
      .ecc_o  ( r_data_ecc[ii]                             )
    );
  end

  assign tgt.gnt     = init.gnt;
  assign tgt.r_valid = init.r_valid;
  assign tgt.r_data  = init.r_data;
  // chunk ecc at the bottom, zeros above
  assign tgt.r_ecc   = {{R_PAD{1'b0}}, r_data_ecc};

  // flags meaningful only while tgt.req is high
  assign err_o = '{
    data_single: data_single,
    data_multi:  data_multi,
    meta_single: meta_single,
    meta_multi:  meta_multi
  };

  // a dropped request must never reach the bank
  always_comb begin
    if (meta_multi) begin
      assert (!init.req)
        else $error("hci_ecc_dec: request forwarded with uncorrectable metadata");
    end
  end

endmodule

// File: verilog/tcdm_sram_bank.sv
`include "tcdm_settings.svh"

module tcdm_sram_bank
  import tcdm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  hci_core_intf.target bus
);

  tcdm_word_t  mem [`TCDM_DEPTH];
  tcdm_waddr_t waddr;
  logic        r_valid_q;
  tcdm_word_t  r_data_q;

  // byte address down to word index
  assign waddr = bus.add[TCDM_BOFFS_W +: $bits(tcdm_waddr_t)];

  // always ready
  assign bus.gnt = 1'b1;

  // one response per accepted request, next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req & bus.gnt;
    end
  end

  // array and read data, contents survive reset
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt) begin
      if (bus.wen) begin
        // enabled bytes only
        for (int unsigned b = 0; b < `TCDM_BW; b++) begin
          if (bus.be[b]) begin
            mem[waddr][b*8 +: 8] <= bus.data[b*8 +: 8];
          end
        end
        // writes answer with zero data
        r_data_q <= '0;
      end else begin
        r_data_q <= mem[waddr];
      end
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;
  // check bits added upstream by hci_ecc_dec
  assign bus.r_ecc   = '0;

  // fixed one-cycle latency, no response without a request
  a_rvalid_after_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (bus.req && bus.gnt) |=> bus.r_valid
  ) else $error("tcdm_sram_bank: missing r_valid after request");

  a_no_spurious_rvalid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !bus.req |=> !bus.r_valid
  ) else $error("tcdm_sram_bank: r_valid without request");

endmodule

// File: verilog/tcdm_ecc_top.sv
`include "tcdm_settings.svh"

module tcdm_ecc_top
  import hci_ecc_pkg::*;
  import tcdm_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // request, ecc covers data chunks and add/wen/be
  input  logic                     req_i,
  input  logic [`TCDM_AW-1:0]      add_i,
  input  logic                     wen_i,
  input  logic [`TCDM_BW-1:0]      be_i,
  input  tcdm_word_t               data_i,
  input  logic [`TCDM_EW-1:0]      ecc_i,
  output logic                     gnt_o,
  // response, one cycle after a forwarded request
  output logic                     r_valid_o,
  output tcdm_word_t               r_data_o,
  output logic [`TCDM_EW-1:0]      r_ecc_o,
  // error flags, same cycle as req_i
  output logic [`TCDM_N_CHUNK-1:0] data_single_err_o,
  output logic [`TCDM_N_CHUNK-1:0] data_multi_err_o,
  output logic                     meta_single_err_o,
  output logic                     meta_multi_err_o
);

  ecc_err_t err;

  // requester side and bank side
  hci_core_intf port_bus ();
  hci_core_intf mem_bus ();

  assign port_bus.req  = req_i;
  assign port_bus.add  = add_i;
  assign port_bus.wen  = wen_i;
  assign port_bus.be   = be_i;
  assign port_bus.data = data_i;
  assign port_bus.ecc  = ecc_i;

  assign gnt_o     = port_bus.gnt;
  assign r_valid_o = port_bus.r_valid;
  assign r_data_o  = port_bus.r_data;
  assign r_ecc_o   = port_bus.r_ecc;

  hci_ecc_dec i_hci_ecc_dec (
    .tgt   ( port_bus.target   ),
    .init  ( mem_bus.initiator ),
    .err_o ( err               )
  );

  tcdm_sram_bank i_tcdm_sram_bank (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .bus     ( mem_bus.target )
  );

  assign data_single_err_o = err.data_single;
  assign data_multi_err_o  = err.data_multi;
  assign meta_single_err_o = err.meta_single;
  assign meta_multi_err_o  = err.meta_multi;

endmodule

// File: sim/tb_tcdm_ecc.sv
`include "tcdm_settings.svh"

module tb_tcdm_ecc
  import hci_ecc_pkg::*;
  import tcdm_pkg::*;
;

  localparam int CLK_P    = 10;
  localparam int PW       = `TCDM_EW_DW;
  localparam int WADDR_W  = $clog2(`TCDM_DEPTH);
  localparam int WORD_LSB = $clog2(`TCDM_BW);
  // requests per test group
  localparam int N_CLEAN  = 64;
  localparam int N_DSGL   = 24;
  localparam int N_DDBL   = 16;
  localparam int N_MSGL   = 16;
  localparam int N_MDBL   = 8;
  localparam int N_REQ    = `TCDM_DEPTH + N_CLEAN + 2 * N_DSGL + N_DDBL + 2 * N_MSGL + 2 * N_MDBL;

  logic                     clk = 1'b0;
  logic                     rst_n_i, req_i, wen_i, gnt_o, r_valid_o;
  logic [`TCDM_AW-1:0]      add_i;
  logic [`TCDM_BW-1:0]      be_i;
  tcdm_word_t               data_i, r_data_o;
  logic [`TCDM_EW-1:0]      ecc_i, r_ecc_o;
  logic [`TCDM_N_CHUNK-1:0] data_single_err_o, data_multi_err_o;
  logic                     meta_single_err_o, meta_multi_err_o;

  // bank model and expected response of the request now on the port
  tcdm_word_t  shadow [`TCDM_DEPTH];
  logic        cur_fwd = 1'b0;
  logic        cur_chk = 1'b0;
  tcdm_word_t  cur_rdata = '0;
  string       cur_name = "idle";
  logic [31:0] lfsr = 32'h5f52;
  int          err_cnt = 0;

  tcdm_ecc_top tcdm_ecc_top_inst (.clk_i(clk), .*);

  always #(CLK_P / 2) clk = ~clk;

  // galois lfsr, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // j-th non-unit odd-weight pattern, weight first then value
  function automatic logic [PW-1:0] ref_col(input int j);
    int            idx;
    logic [PW-1:0] col;
    idx = 0;
    col = '0;
    for (int w = 3; w <= PW; w += 2) begin
      for (int v = 1; v < (1 << PW); v++) begin
        if ($countones(v) == w) begin
          if (idx == j) col = PW'(v);
          idx++;
        end
      end
    end
    return col;
  endfunction

  function automatic logic [PW-1:0] ref_enc(input logic [31:0] d, input int n);
    logic [PW-1:0] c;
    c = '0;
    for (int j = 0; j < n; j++) begin
      if (d[j]) c ^= ref_col(j);
    end
    return c;
  endfunction

  // returns {single, multi}
  function automatic logic [1:0] ref_dec(input logic [31:0] d, input int n,
                                         input logic [PW-1:0] c, output logic [31:0] fixed);
    logic [PW-1:0] syn;
    logic          hit;
    logic          unit;
    syn   = c ^ ref_enc(d, n);
    fixed = d;
    hit   = 1'b0;
    for (int j = 0; j < n; j++) begin
      if (syn == ref_col(j)) begin
        fixed[j] = ~d[j];
        hit      = 1'b1;
      end
    end
    unit = $onehot(syn);
    return {hit | unit, (syn != '0) & ~hit & ~unit};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one request, optional bit flips on the wire
  task automatic issue(input string name, input logic [`TCDM_AW-1:0] add, input logic wen,
                       input logic [`TCDM_BW-1:0] be, input tcdm_word_t data, input logic chk,
                       input logic [`TCDM_META_W-1:0] meta_flip, input tcdm_word_t data_flip,
                       input logic [`TCDM_EW-1:0] ecc_flip);
    tcdm_meta_t               meta, meta_tx, meta_fix;
    ecc_word_u                ecc, ecc_tx;
    tcdm_word_t               data_tx, data_fix, exp_rdata;
    logic [31:0]              fix;
    logic [1:0]               f, mflag;
    logic [`TCDM_N_CHUNK-1:0] ds, dm;
    meta = '{add: add, wen: wen, be: be};
    for (int i = 0; i < `TCDM_N_CHUNK; i++) begin
      ecc.fields.data_ecc[i] = ref_enc(data[i*`TCDM_CHUNK +: `TCDM_CHUNK], `TCDM_CHUNK);
    end
    ecc.fields.meta_ecc = ref_enc(32'(meta), `TCDM_META_W);
    meta_tx    = meta ^ meta_flip;
    data_tx    = data ^ data_flip;
    ecc_tx.raw = ecc.raw ^ ecc_flip;
    // what the decoders should make of the faulty word
    for (int i = 0; i < `TCDM_N_CHUNK; i++) begin
      f = ref_dec(data_tx[i*`TCDM_CHUNK +: `TCDM_CHUNK], `TCDM_CHUNK,
                  ecc_tx.fields.data_ecc[i], fix);
      ds[i] = f[1];
      dm[i] = f[0];
      data_fix[i*`TCDM_CHUNK +: `TCDM_CHUNK] = fix;
    end
    mflag    = ref_dec(32'(meta_tx), `TCDM_META_W, ecc_tx.fields.meta_ecc, fix);
    meta_fix = tcdm_meta_t'(fix[`TCDM_META_W-1:0]);
    exp_rdata = '0;
    // dropped request leaves the model untouched
    if (!mflag[0]) begin
      if (meta_fix.wen) begin
        for (int b = 0; b < `TCDM_BW; b++) begin
          if (meta_fix.be[b]) begin
            shadow[meta_fix.add[WORD_LSB +: WADDR_W]][b*8 +: 8] = data_fix[b*8 +: 8];
          end
        end
      end else begin
        exp_rdata = shadow[meta_fix.add[WORD_LSB +: WADDR_W]];
      end
    end
    @(posedge clk);
    #1;
    req_i  = 1'b1;
    add_i  = meta_tx.add;
    wen_i  = meta_tx.wen;
    be_i   = meta_tx.be;
    data_i = data_tx;
    ecc_i  = ecc_tx.raw;
    cur_fwd   = ~mflag[0];
    cur_chk   = chk;
    cur_rdata = exp_rdata;
    cur_name  = name;
    // flags settle well before the next edge
    #3;
    check({name, " err flags"}, 64'({ds, dm, mflag}),
          64'({data_single_err_o, data_multi_err_o, meta_single_err_o, meta_multi_err_o}));
    // bank always accepts
    check({name, " gnt"}, 64'(1'b1), 64'(gnt_o));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    req_i   = 1'b0;
    cur_fwd = 1'b0;
    cur_chk = 1'b0;
    cur_name = "idle";
  endtask

  // response of the previous cycle's request, sampled mid-cycle
  initial begin : compare_resp
    logic       prev_fwd;
    logic       prev_chk;
    tcdm_word_t prev_rdata;
    string      prev_name;
    prev_fwd = 1'b0;
    prev_chk = 1'b0;
    prev_rdata = '0;
    prev_name = "idle";
    @(posedge rst_n_i);
    forever begin
      @(negedge clk);
      check({prev_name, " r_valid"}, 64'(prev_fwd), 64'(r_valid_o));
      if (prev_fwd) begin
        if (prev_chk) check({prev_name, " r_data"}, prev_rdata, r_data_o);
        // upper pad zero, chunk 1 above chunk 0
        check({prev_name, " r_ecc"},
              64'({{(`TCDM_EW - `TCDM_N_CHUNK * PW){1'b0}},
                   ref_enc(r_data_o[`TCDM_CHUNK +: `TCDM_CHUNK], `TCDM_CHUNK),
                   ref_enc(r_data_o[0 +: `TCDM_CHUNK], `TCDM_CHUNK)}),
              64'(r_ecc_o));
      end
      prev_fwd   = cur_fwd;
      prev_chk   = cur_chk;
      prev_rdata = cur_rdata;
      prev_name  = cur_name;
    end
  end

  initial begin : watchdog
    #(20 * N_REQ * CLK_P);
    $display("timeout: tests did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [`TCDM_AW-1:0] a;
    tcdm_word_t          d, dflip;
    logic [`TCDM_EW-1:0] eflip;
    logic [`TCDM_META_W-1:0] mflip;
    int                  p, q, c;
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    add_i   = '0;
    wen_i   = 1'b0;
    be_i    = '0;
    data_i  = '0;
    ecc_i   = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    // every word written once so later reads are defined
    for (int w = 0; w < `TCDM_DEPTH; w++) begin
      issue("fill", `TCDM_AW'(w << WORD_LSB), 1'b1, '1, rand_bits(64), 1'b1, '0, '0, '0);
    end
    for (int k = 0; k < N_CLEAN; k++) begin
      issue("clean", `TCDM_AW'(rand_bits(`TCDM_AW)), 1'(rand_bits(1)),
            `TCDM_BW'(rand_bits(`TCDM_BW)), rand_bits(64), 1'b1, '0, '0, '0);
    end
    // one flip in data or data check bits, then read back
    for (int k = 0; k < N_DSGL; k++) begin
      a = `TCDM_AW'(rand_bits(`TCDM_AW));
      p = int'(rand_bits(7)) % (`TCDM_DW + `TCDM_N_CHUNK * PW);
      dflip = '0;
      eflip = '0;
      if (p < `TCDM_DW) dflip[p] = 1'b1;
      else eflip[`TCDM_EW_META + p - `TCDM_DW] = 1'b1;
      issue("data_single_wr", a, 1'b1, `TCDM_BW'(rand_bits(`TCDM_BW)), rand_bits(64), 1'b1,
            '0, dflip, eflip);
      issue("data_single_rd", a, 1'b0, '0, '0, 1'b1, '0, '0, '0);
    end
    // two flips in one chunk, read data not compared
    for (int k = 0; k < N_DDBL; k++) begin
      p = int'(rand_bits(5));
      q = int'(rand_bits(5));
      c = int'(rand_bits(1));
      if (q == 0) q = 1;
      dflip = '0;
      dflip[c * `TCDM_CHUNK + p] = 1'b1;
      dflip[c * `TCDM_CHUNK + (p ^ q)] = 1'b1;
      issue("data_double_rd", `TCDM_AW'(rand_bits(`TCDM_AW)), 1'b0, '0, rand_bits(64), 1'b0,
            '0, dflip, '0);
    end
    // address bit flipped, access must still hit the intended word
    for (int k = 0; k < N_MSGL; k++) begin
      a = `TCDM_AW'(rand_bits(`TCDM_AW));
      mflip = '0;
      mflip[`TCDM_META_W - `TCDM_AW + int'(rand_bits(4)) % `TCDM_AW] = 1'b1;
      issue("meta_single_wr", a, 1'b1, '1, rand_bits(64), 1'b1, mflip, '0, '0);
      issue("meta_single_rd", a, 1'b0, '0, '0, 1'b1, '0, '0, '0);
    end
    // two metadata flips drop the write, clean read sees old word
    for (int k = 0; k < N_MDBL; k++) begin
      a = `TCDM_AW'(rand_bits(`TCDM_AW));
      p = int'(rand_bits(5)) % `TCDM_META_W;
      q = 1 + int'(rand_bits(5)) % (`TCDM_META_W - 1);
      mflip = '0;
      mflip[p] = 1'b1;
      mflip[(p + q) % `TCDM_META_W] = 1'b1;
      issue("meta_double_wr", a, 1'b1, '1, rand_bits(64), 1'b1, mflip, '0, '0);
      issue("meta_double_rd", a, 1'b0, '0, '0, 1'b1, '0, '0, '0);
    end
    idle_cycle();
    idle_cycle();
    idle_cycle();
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/hci_ecc_pkg.sv
common/tcdm_pkg.sv
common/hci_core_intf.sv
ecc/hsiao_ecc_enc.sv
ecc/hsiao_ecc_dec.sv
ecc/hci_ecc_dec.sv
verilog/tcdm_sram_bank.sv
verilog/tcdm_ecc_top.sv
sim/tb_tcdm_ecc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, result decided by the pass line in the output
verilator --binary --timing --assert -f compile.f --top-module tb_tcdm_ecc -o sim_tb \
  || { echo "run_sim: build failed"; exit 1; }
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }
